// File: source/clkmgmt_macros.svh
`ifndef CLKMGMT_MACROS_SVH
`define CLKMGMT_MACROS_SVH

// Register bus widths
`define CM_ADDR_WIDTH      8
`define CM_DATA_WIDTH      8
`define CM_BYTECNT_SIZE    7

// DRP and phase widths
`define CM_DRP_ADDR_WIDTH  7
`define CM_DRP_DATA_WIDTH  16
`define CM_PHASE_WIDTH     16

// Register map
`define CM_REG_DRP_ADDR    8'd62   // 7-bit DRP address, one byte
`define CM_REG_DRP_DATA    8'd63   // 16-bit DRP data, two bytes
`define CM_REG_DRP_RESET   8'd64   // bit 0 reconfig reset, bit 1 lock
`define CM_REG_PHASE       8'd72   // requested phase step, two bytes
`define CM_REG_PHASE_POS   8'd73   // current position, read only

// Clock tile timing
`define CM_PS_LATENCY      4       // psen to psdone
`define CM_LOCK_CYCLES     20      // reset release to lock

`endif

// File: source/clkmgmt_pkg.sv
`include "clkmgmt_macros.svh"

package clkmgmt_pkg;

    // Byte-wide register bus as seen by every register block
    typedef struct packed {
        logic [`CM_ADDR_WIDTH-1:0]   address;
        logic [`CM_BYTECNT_SIZE-1:0] bytecnt;
        logic [`CM_DATA_WIDTH-1:0]   datai;
        logic                        write;
        logic                        read;
    } reg_bus_t;

    // DRP request towards the clock generator
    typedef struct packed {
        logic [`CM_DRP_ADDR_WIDTH-1:0] addr;
        logic [`CM_DRP_DATA_WIDTH-1:0] din;
        logic                          den;
        logic                          dwe;   // Write when set with den
    } drp_req_t;

    // DRP response, drdy one cycle after den
    typedef struct packed {
        logic [`CM_DRP_DATA_WIDTH-1:0] dout;
        logic                          drdy;
    } drp_rsp_t;

    // Phase shift request
    typedef struct packed {
        logic psen;
        logic psincdec;   // 1 = increment
    } ps_req_t;

    // Signed phase step index
    typedef logic signed [`CM_PHASE_WIDTH-1:0] phase_t;

endpackage

// File: source/clkmgmt_reg_shadow.sv
`timescale 1ns/1ps
`include "clkmgmt_macros.svh"

module clkmgmt_reg_shadow #(
    parameter type T    = clkmgmt_pkg::phase_t,
    parameter int  ADDR = 0
) (
    input  logic                  clk_usb,
    input  logic                  rst_n,
    input  clkmgmt_pkg::reg_bus_t bus,
    output T                      value,
    output logic                  last_wr
);

    localparam int NBITS  = $bits(T);
    localparam int NBYTES = (NBITS + 7) / 8;

    logic [NBYTES*8-1:0] shadow;   // Whole bytes, top bits may be spare
    logic                hit;
    int                  lane;

    assign hit  = bus.write && (bus.address == `CM_ADDR_WIDTH'(ADDR));
    assign lane = int'(bus.bytecnt);

    // Little-endian, byte n lands at bytecnt n
    always_ff @(posedge clk_usb or negedge rst_n) begin
        if (!rst_n) begin
            shadow <= '0;
        end else if (hit) begin
            for (int i = 0; i < NBYTES; i++) begin
                if (lane == i) begin
                    shadow[i*8 +: 8] <= bus.datai;
                end
            end
        end
    end

    // Strobe with the write of the top byte
    assign last_wr = hit && (lane == NBYTES - 1);

    assign value = T'(shadow[NBITS-1:0]);

endmodule

// File: source/clkmgmt_step_counter.sv
`timescale 1ns/1ps

module clkmgmt_step_counter (
    input  logic                clk_usb,
    input  logic                rst_n,
    input  logic                step,
    input  logic                up,
    output clkmgmt_pkg::phase_t count
);

    clkmgmt_pkg::phase_t count_q;
    clkmgmt_pkg::phase_t count_nxt;

    // Plain 16-bit wrap, same as the tile's own position
    always_comb begin
        if (up) begin
            count_nxt = count_q + 16'sd1;
        end else begin
            count_nxt = count_q - 16'sd1;
        end
    end

    always_ff @(posedge clk_usb or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (step) begin
            count_q <= count_nxt;
        end
    end

    assign count = count_q;

endmodule

// File: source/clkmgmt_phase_fsm.sv
`timescale 1ns/1ps

module clkmgmt_phase_fsm (
    input  logic                 clk_usb,
    input  logic                 rst_n,
    input  logic                 load,
    input  clkmgmt_pkg::phase_t  target,
    input  clkmgmt_pkg::phase_t  count,
    output clkmgmt_pkg::ps_req_t ps_req,
    input  logic                 psdone,
    output logic                 step,
    output logic                 up,
    output logic                 done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_SHIFT,
        ST_WAIT
    } state_t;

    state_t              state;
    clkmgmt_pkg::phase_t target_q;
    logic                up_q;
    logic                done_q;

    always_ff @(posedge clk_usb or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            target_q <= '0;
            up_q     <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (load) begin   // Loads while busy never reach here
                        target_q <= target;
                        state    <= ST_COMPARE;
                    end
                end
                ST_COMPARE: begin
                    if (count == target_q) begin
                        done_q <= 1'b1;
                        state  <= ST_IDLE;
                    end else begin
                        up_q  <= (target_q > count);   // Signed compare
                        state <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    state <= ST_WAIT;   // psen goes out this cycle
                end
                ST_WAIT: begin
                    if (psdone) begin
                        state <= ST_COMPARE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Single psen cycle per step, direction held alongside
    assign ps_req.psen     = (state == ST_SHIFT);
    assign ps_req.psincdec = up_q;

    // Counter moves on the same edge the tile does
    assign step = (state == ST_WAIT) && psdone;
    assign up   = up_q;
    assign done = done_q;

endmodule

// File: source/clkmgmt_drp_regs.sv
`timescale 1ns/1ps
`include "clkmgmt_macros.svh"

module clkmgmt_drp_regs (
    input  logic                  clk_usb,
    input  logic                  rst_n,
    input  clkmgmt_pkg::reg_bus_t bus,
    output clkmgmt_pkg::drp_req_t drp_req,
    input  clkmgmt_pkg::drp_rsp_t drp_rsp,
    output logic                  drp_reset,
    output logic [15:0]           read_word
);

    typedef logic [`CM_DRP_ADDR_WIDTH-1:0] drp_addr_t;
    typedef logic [`CM_DRP_DATA_WIDTH-1:0] drp_data_t;

    drp_addr_t addr_q;
    drp_data_t data_q;
    logic      addr_last;
    logic      data_last;
    logic      reset_wr;
    logic      den_q;
    logic      dwe_q;
    logic      busy_q;       // den issued, drdy not yet seen
    logic      rd_pend_q;    // Outstanding access is a read
    logic      rd_valid_q;
    logic      reset_q;
    drp_data_t capt_q;

    clkmgmt_reg_shadow #(
        .T    (drp_addr_t),
        .ADDR (`CM_REG_DRP_ADDR)
    ) u_addr_shadow (
        .clk_usb (clk_usb),
        .rst_n   (rst_n),
        .bus     (bus),
        .value   (addr_q),
        .last_wr (addr_last)
    );

    clkmgmt_reg_shadow #(
        .T    (drp_data_t),
        .ADDR (`CM_REG_DRP_DATA)
    ) u_data_shadow (
        .clk_usb (clk_usb),
        .rst_n   (rst_n),
        .bus     (bus),
        .value   (data_q),
        .last_wr (data_last)
    );

    assign reset_wr = bus.write && (bus.address == `CM_REG_DRP_RESET) && (bus.bytecnt == '0);

    always_ff @(posedge clk_usb or negedge rst_n) begin
        if (!rst_n) begin
            den_q      <= 1'b0;
            dwe_q      <= 1'b0;
            busy_q     <= 1'b0;
            rd_pend_q  <= 1'b0;
            rd_valid_q <= 1'b0;
            reset_q    <= 1'b0;
        end else begin
            den_q <= 1'b0;
            dwe_q <= 1'b0;
            if ((addr_last || data_last) && !busy_q) begin   // Dropped if busy
                den_q     <= 1'b1;
                dwe_q     <= data_last;
                busy_q    <= 1'b1;
                rd_pend_q <= addr_last;
            end else if (drp_rsp.drdy) begin
                busy_q <= 1'b0;
                if (rd_pend_q) begin
                    rd_valid_q <= 1'b1;
                end
            end
            if (data_last) begin
                rd_valid_q <= 1'b0;   // Fresh write shows until next read
            end
            if (reset_wr) begin
                reset_q <= bus.datai[0];
            end
        end
    end

    always_ff @(posedge clk_usb) begin
        if (drp_rsp.drdy && rd_pend_q) begin
            capt_q <= drp_rsp.dout;
        end
    end

    assign drp_req.addr = addr_q;
    assign drp_req.din  = data_q;
    assign drp_req.den  = den_q;
    assign drp_req.dwe  = dwe_q;
    assign drp_reset    = reset_q;
    assign read_word    = rd_valid_q ? capt_q : data_q;

endmodule

// File: source/clkmgmt_mmcm_model.sv
`timescale 1ns/1ps
`include "clkmgmt_macros.svh"

module clkmgmt_mmcm_model (
    input  logic                  clk_usb,
    input  logic                  rst_n,
    input  clkmgmt_pkg::drp_req_t drp_req,
    output clkmgmt_pkg::drp_rsp_t drp_rsp,
    input  logic                  drp_reset,
    input  clkmgmt_pkg::ps_req_t  ps_req,
    output logic                  psdone,
    output clkmgmt_pkg::phase_t   phase,
    output logic                  locked
);

    localparam int LAT = `CM_PS_LATENCY;
    localparam int LW  = $clog2(`CM_LOCK_CYCLES + 1);

    logic [`CM_DRP_DATA_WIDTH-1:0] drp_mem [0:(1 << `CM_DRP_ADDR_WIDTH)-1];
    logic [`CM_DRP_DATA_WIDTH-1:0] dout_q;
    logic                          drdy_q;
    logic [LAT-1:0]                ps_pipe;   // psen delay line
    logic                          ps_dir;
    clkmgmt_pkg::phase_t           phase_q;
    logic [LW-1:0]                 lock_cnt;

    // DRP register file, survives the reconfig reset
    always_ff @(posedge clk_usb) begin
        if (drp_req.den && drp_req.dwe) begin
            drp_mem[drp_req.addr] <= drp_req.din;
        end
        if (drp_req.den && !drp_req.dwe) begin
            dout_q <= drp_mem[drp_req.addr];
        end
    end

    always_ff @(posedge clk_usb or negedge rst_n) begin
        if (!rst_n) begin
            drdy_q   <= 1'b0;
            ps_pipe  <= '0;
            ps_dir   <= 1'b0;
            phase_q  <= '0;
            lock_cnt <= '0;
        end else begin
            drdy_q  <= drp_req.den;
            ps_pipe <= {ps_pipe[LAT-2:0], ps_req.psen};
            if (ps_req.psen) begin
                ps_dir <= ps_req.psincdec;
            end
            if (ps_pipe[LAT-1]) begin
                phase_q <= ps_dir ? phase_q + 16'sd1 : phase_q - 16'sd1;
            end
            if (drp_reset) begin
                lock_cnt <= '0;
            end else if (lock_cnt != LW'(`CM_LOCK_CYCLES)) begin
                lock_cnt <= lock_cnt + 1'b1;
            end
        end
    end

    assign drp_rsp.dout = dout_q;
    assign drp_rsp.drdy = drdy_q;
    assign psdone       = ps_pipe[LAT-1];
    assign phase        = phase_q;
    assign locked       = (lock_cnt == LW'(`CM_LOCK_CYCLES)) && !drp_reset;

endmodule

// File: source/clock_management_ctrl.sv
`timescale 1ns/1ps
`include "clkmgmt_macros.svh"

module clock_management_ctrl (
    input  logic                       clk_usb,
    input  logic                       rst_n,
    input  logic [`CM_ADDR_WIDTH-1:0]  reg_address,
    input  logic [`CM_BYTECNT_SIZE-1:0] reg_bytecnt,
    input  logic [`CM_DATA_WIDTH-1:0]  reg_datai,
    output logic [`CM_DATA_WIDTH-1:0]  reg_datao,
    input  logic                       reg_read,
    input  logic                       reg_write,
    input  logic                       phase_load,
    output logic                       phase_done,
    output logic                       dcm_gen_locked,
    output clkmgmt_pkg::phase_t        mmcm_phase
);

    clkmgmt_pkg::reg_bus_t bus;
    clkmgmt_pkg::phase_t   phase_target;
    clkmgmt_pkg::phase_t   phase_pos;
    clkmgmt_pkg::ps_req_t  ps_req;
    clkmgmt_pkg::drp_req_t drp_req;
    clkmgmt_pkg::drp_rsp_t drp_rsp;
    logic                  psdone;
    logic                  step;
    logic                  up;
    logic                  drp_reset;
    logic                  locked;
    logic [15:0]           drp_word;

    function automatic logic [7:0] byte_of(input logic [15:0] word,
                                           input logic [`CM_BYTECNT_SIZE-1:0] idx);
        logic [7:0] b;
        case (idx)
            'd0:     b = word[7:0];
            'd1:     b = word[15:8];
            default: b = 8'h00;
        endcase
        return b;
    endfunction

    assign bus.address = reg_address;
    assign bus.bytecnt = reg_bytecnt;
    assign bus.datai   = reg_datai;
    assign bus.write   = reg_write;
    assign bus.read    = reg_read;

    // Walk starts from phase_load, the target strobe is not needed
    clkmgmt_reg_shadow #(
        .T    (clkmgmt_pkg::phase_t),
        .ADDR (`CM_REG_PHASE)
    ) u_phase_shadow (
        .clk_usb (clk_usb), .rst_n (rst_n), .bus (bus),
        .value   (phase_target), .last_wr ()
    );

    clkmgmt_phase_fsm u_phase_fsm (
        .clk_usb (clk_usb), .rst_n (rst_n), .load (phase_load),
        .target  (phase_target), .count (phase_pos), .ps_req (ps_req),
        .psdone  (psdone), .step (step), .up (up), .done (phase_done)
    );

    clkmgmt_step_counter u_step_counter (
        .clk_usb (clk_usb), .rst_n (rst_n), .step (step), .up (up), .count (phase_pos)
    );

    clkmgmt_drp_regs u_drp_regs (
        .clk_usb   (clk_usb), .rst_n (rst_n), .bus (bus),
        .drp_req   (drp_req), .drp_rsp (drp_rsp),
        .drp_reset (drp_reset), .read_word (drp_word)
    );

    clkmgmt_mmcm_model u_mmcm (
        .clk_usb   (clk_usb), .rst_n (rst_n), .drp_req (drp_req), .drp_rsp (drp_rsp),
        .drp_reset (drp_reset), .ps_req (ps_req), .psdone (psdone),
        .phase     (mmcm_phase), .locked (locked)
    );

    assign dcm_gen_locked = locked;

    // Read mux straight off address and bytecnt
    always_comb begin
        reg_datao = 8'h00;
        if (bus.read) begin
            case (bus.address)
                `CM_REG_PHASE:     reg_datao = byte_of(phase_target, bus.bytecnt);
                `CM_REG_PHASE_POS: reg_datao = byte_of(phase_pos, bus.bytecnt);
                `CM_REG_DRP_DATA:  reg_datao = byte_of(drp_word, bus.bytecnt);
                `CM_REG_DRP_RESET: reg_datao = byte_of({14'd0, locked, drp_reset}, bus.bytecnt);
                default:           reg_datao = 8'h00;
            endcase
        end
    end

endmodule

// File: tests/clock_management_properties.sv
`timescale 1ns/1ps
`include "clkmgmt_macros.svh"

module clock_management_properties #(
    parameter bit CHECK_DRP = 1'b1
) (
    input logic clk_usb,
    input logic rst_n,
    input logic psen,
    input logic psdone,
    input logic den,
    input logic drdy
);

    logic step_pending;   // psen seen, psdone not yet
    int   fail_cnt = 0;   // Failed assertions so far

    always_ff @(posedge clk_usb or negedge rst_n) begin
        if (!rst_n) begin
            step_pending <= 1'b0;
        end else if (psen) begin
            step_pending <= 1'b1;
        end else if (psdone) begin
            step_pending <= 1'b0;
        end
    end

    // One phase step at a time
    no_psen_while_pending: assert property (@(posedge clk_usb) disable iff (!rst_n)
        step_pending |-> !psen)
        else begin
            fail_cnt++;
            $error("psen raised while a phase step was still outstanding");
        end

    psdone_latency: assert property (@(posedge clk_usb) disable iff (!rst_n)
        psen |-> ##(`CM_PS_LATENCY) psdone)
        else begin
            fail_cnt++;
            $error("psdone did not follow psen after the phase shift latency");
        end

    // Only where a DRP port exists
    if (CHECK_DRP) begin : g_drp
        drdy_after_den: assert property (@(posedge clk_usb) disable iff (!rst_n)
            den |=> drdy)
            else begin
                fail_cnt++;
                $error("drdy did not follow den by one cycle");
            end
    end

endmodule

bind clkmgmt_phase_fsm clock_management_properties #(.CHECK_DRP(1'b0)) props_fsm (
    .clk_usb (clk_usb), .rst_n (rst_n), .psen (ps_req.psen), .psdone (psdone),
    .den (1'b0), .drdy (1'b0)
);

bind clkmgmt_mmcm_model clock_management_properties props_mmcm (
    .clk_usb (clk_usb), .rst_n (rst_n), .psen (ps_req.psen), .psdone (psdone),
    .den (drp_req.den), .drdy (drp_rsp.drdy)
);

// File: tests/clock_management_tb.sv
`timescale 1ns/1ps
`include "clkmgmt_macros.svh"

module clock_management_tb;

    typedef enum logic [1:0] {OP_DRP_WR, OP_DRP_RD, OP_PHASE, OP_DRP_RST} op_t;
    typedef struct packed {
        op_t         op;
        logic [7:0]  addr;
        logic [15:0] value;
        logic [15:0] exp_val;
    } stim_t;

    localparam int N_STIM    = 11;
    localparam int N_RAND    = 6;
    localparam int MAX_STEP  = 64;   // Largest phase span in one move
    localparam int RUN_LIMIT = (N_STIM + N_RAND) *
        (MAX_STEP * (`CM_PS_LATENCY + 3) + `CM_LOCK_CYCLES + 50) + 16;

    logic clk_usb, rst_n, reg_read, reg_write, phase_load;
    logic phase_done, dcm_gen_locked;
    logic [7:0] reg_address, reg_datai, reg_datao;
    logic [`CM_BYTECNT_SIZE-1:0] reg_bytecnt;
    clkmgmt_pkg::phase_t mmcm_phase;
    clkmgmt_pkg::phase_t model_pos;   // Expected position
    stim_t  stim [0:N_STIM-1];
    int     value_errs = 0;
    int     timeout_errs = 0;
    int     cycle_cnt = 0;
    integer seed = 32'hb3f4_fe9d;

    clock_management_ctrl UUT (.*);

    initial begin
        clk_usb = 1'b0;
        forever #20 clk_usb = ~clk_usb;
    end

    always @(posedge clk_usb) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > RUN_LIMIT) begin
            $display("Run timeout: simulation exceeded %0d cycles", RUN_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic bus_write(input logic [7:0] addr, input int idx, input logic [7:0] data);
        @(posedge clk_usb);
        #2;
        reg_address = addr;
        reg_bytecnt = idx[`CM_BYTECNT_SIZE-1:0];
        reg_datai   = data;
        reg_write   = 1'b1;
        @(posedge clk_usb);
        #2;
        reg_write = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, input int idx, output logic [7:0] data);
        @(posedge clk_usb);
        #2;
        reg_address = addr;
        reg_bytecnt = idx[`CM_BYTECNT_SIZE-1:0];
        reg_read    = 1'b1;
        #5 data = reg_datao;   // Mid-cycle, mux settled
        @(posedge clk_usb);
        #2;
        reg_read = 1'b0;
    endtask

    task automatic read_word(input logic [7:0] addr, output logic [15:0] word);
        logic [7:0] lo, hi;
        bus_read(addr, 0, lo);
        bus_read(addr, 1, hi);
        word = {hi, lo};
    endtask

    task automatic check_word(input logic [15:0] got, input logic [15:0] want,
                              input string what);
        assert (got === want) else begin
            value_errs++;
            $display("FAIL %0t: %s read %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic drp_read_check(input logic [7:0] addr, input logic [15:0] want);
        logic [15:0] word;
        bus_write(`CM_REG_DRP_ADDR, 0, addr);   // Address write issues the read
        repeat (4) @(posedge clk_usb);
        read_word(`CM_REG_DRP_DATA, word);
        check_word(word, want, "DRP data");
    endtask

    task automatic move_phase(input clkmgmt_pkg::phase_t target,
                              input clkmgmt_pkg::phase_t want);
        int steps, limit, cycles;
        logic [15:0] word;
        steps  = int'(target) - int'(model_pos);
        steps  = (steps < 0) ? -steps : steps;
        limit  = steps * (`CM_PS_LATENCY + 3) + 10;
        bus_write(`CM_REG_PHASE, 0, target[7:0]);
        bus_write(`CM_REG_PHASE, 1, target[15:8]);
        @(posedge clk_usb);
        #2 phase_load = 1'b1;
        @(posedge clk_usb);
        #2 phase_load = 1'b0;
        cycles = 1;
        while (!phase_done && cycles <= limit) begin
            @(posedge clk_usb);
            #1;
            cycles++;
        end
        if (!phase_done) begin
            timeout_errs++;
            $display("Timeout: phase_done never came for target %0d", target);
        end
        if (steps == 0) begin
            assert (cycles == 2) else begin
                value_errs++;
                $display("FAIL %0t: zero-step done after %0d cycles", $time, cycles);
            end
        end
        model_pos = want;
        read_word(`CM_REG_PHASE_POS, word);
        check_word(word, model_pos, "phase position");
        check_word(mmcm_phase, model_pos, "mmcm_phase");
    endtask

    task automatic pulse_drp_reset(input logic [7:0] addr, input logic [15:0] want);
        logic [7:0] rb;
        int waited;
        bus_write(`CM_REG_DRP_RESET, 0, 8'h01);
        @(posedge clk_usb);
        #1;
        bus_read(`CM_REG_DRP_RESET, 0, rb);
        assert (!dcm_gen_locked && rb[1:0] == 2'b01) else begin
            value_errs++;
            $display("FAIL %0t: lock %b, reset byte %h while in reset", $time,
                     dcm_gen_locked, rb);
        end
        bus_write(`CM_REG_DRP_RESET, 0, 8'h00);
        waited = 1;
        while (!dcm_gen_locked && waited <= `CM_LOCK_CYCLES + 2) begin
            @(posedge clk_usb);
            #1;
            waited++;
        end
        if (!dcm_gen_locked) begin
            timeout_errs++;
            $display("Timeout: lock did not return after the DRP reset was cleared");
        end
        drp_read_check(addr, want);   // DRP file survives the reset
    endtask

    task automatic build_stim;
        stim[0]  = '{OP_DRP_WR,  8'h05, 16'h1234, 16'h0000};
        stim[1]  = '{OP_DRP_WR,  8'h21, 16'habcd, 16'h0000};
        stim[2]  = '{OP_DRP_WR,  8'h7f, 16'h0f0f, 16'h0000};
        stim[3]  = '{OP_DRP_WR,  8'h05, 16'h5a5a, 16'h0000};   // Overwrite
        stim[4]  = '{OP_DRP_RD,  8'h21, 16'h0000, 16'habcd};
        stim[5]  = '{OP_DRP_RD,  8'h05, 16'h0000, 16'h5a5a};
        stim[6]  = '{OP_DRP_RD,  8'h7f, 16'h0000, 16'h0f0f};
        stim[7]  = '{OP_PHASE,   8'h00, 16'h0005, 16'h0005};
        stim[8]  = '{OP_PHASE,   8'h00, 16'hfffd, 16'hfffd};   // 8 steps down
        stim[9]  = '{OP_PHASE,   8'h00, 16'hfffd, 16'hfffd};   // Zero steps
        stim[10] = '{OP_DRP_RST, 8'h21, 16'h0000, 16'habcd};
    endtask

    initial begin
        logic [15:0] word;
        int delta;
        int prop_errs;
        clkmgmt_pkg::phase_t target;
        rst_n       = 1'b0;
        reg_read    = 1'b0;
        reg_write   = 1'b0;
        phase_load  = 1'b0;
        reg_address = '0;
        reg_bytecnt = '0;
        reg_datai   = '0;
        model_pos = '0;
        build_stim();
        repeat (16) @(posedge clk_usb);
        #2 rst_n = 1'b1;
        read_word(`CM_REG_PHASE_POS, word);
        check_word(word, 16'h0000, "position after reset");
        for (int i = 0; i < N_STIM; i++) begin
            case (stim[i].op)
                OP_DRP_WR: begin
                    bus_write(`CM_REG_DRP_ADDR, 0, stim[i].addr);
                    repeat (4) @(posedge clk_usb);
                    bus_write(`CM_REG_DRP_DATA, 0, stim[i].value[7:0]);
                    bus_write(`CM_REG_DRP_DATA, 1, stim[i].value[15:8]);
                    repeat (4) @(posedge clk_usb);
                end
                OP_DRP_RD:  drp_read_check(stim[i].addr, stim[i].exp_val);
                OP_PHASE:   move_phase(stim[i].value, stim[i].exp_val);
                default:    pulse_drp_reset(stim[i].addr, stim[i].exp_val);
            endcase
        end
        for (int r = 0; r < N_RAND; r++) begin
            delta  = $random(seed) % (MAX_STEP + 1);   // Span -64 to +64
            target = clkmgmt_pkg::phase_t'(model_pos + delta);
            move_phase(target, target);
        end
        prop_errs = UUT.u_phase_fsm.props_fsm.fail_cnt + UUT.u_mmcm.props_mmcm.fail_cnt;
        $display("Errors: %0d value, %0d timeout, %0d assertion", value_errs, timeout_errs,
                 prop_errs);
        if (value_errs == 0 && timeout_errs == 0 && prop_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+source
source/clkmgmt_pkg.sv
source/clkmgmt_reg_shadow.sv
source/clkmgmt_step_counter.sv
source/clkmgmt_phase_fsm.sv
source/clkmgmt_drp_regs.sv
source/clkmgmt_mmcm_model.sv
source/clock_management_ctrl.sv
tests/clock_management_properties.sv
tests/clock_management_tb.sv
